//--- addr_decode.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module addr_decode (
    input  ctrl_pkg::req_src_t     src,
    input  logic                   is_read,
    input  logic [`SS_ADDR_W-1:0]  addr,
    output ctrl_pkg::dest_t        dest
);

    import ctrl_pkg::*;

    logic in_mb;
    logic in_aa;
    logic in_local;
    logic in_user;

    assign in_mb    = (addr >= `MB_LOW) && (addr <= `MB_HIGH);
    assign in_aa    = (addr >= `AA_LOW) && (addr <= `AA_HIGH);
    assign in_local = (addr >= `MB_LOW) && (addr <= `LOCAL_HIGH);
    // window 0 starts at address zero
    assign in_user  = (addr <= `USER0_HIGH) ||
                      ((addr >= `USER1_LOW) && (addr <= `USER1_HIGH));

    always_comb begin
        dest = DEST_DROP;
        if (src == SRC_SS) begin
            // remote side may only write the mailbox
            dest = in_mb ? DEST_MB_WR : DEST_DROP;
        end else if (is_read) begin
            if (in_mb)
                dest = DEST_MB_RD;
            else if (in_aa)
                dest = DEST_AA_RD;
            else if (in_local)
                dest = DEST_UNSUPP_RD;
            else if (in_user)
                dest = DEST_FWD_RD;
            else
                dest = DEST_UNSUPP_RD;
        end else begin
            if (in_mb)
                dest = DEST_MB_WR;
            else if (in_aa)
                dest = DEST_AA_WR;
            else if (in_user)
                dest = DEST_FWD_WR;
            // holes in the local block and outside every window are ignored
        end
    end

endmodule

//--- axi_ctrl_logic.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module axi_ctrl_logic (
    input  logic                axi_aclk,
    input  logic                axi_aresetn,
    output logic                axi_interrupt,

    // LS side, register access requests
    input  logic                bk_ls_wstart,
    input  logic [`ADDR_W-1:0]  bk_ls_waddr,
    input  logic [`DATA_W-1:0]  bk_ls_wdata,
    input  logic [`STRB_W-1:0]  bk_ls_wstrb,
    input  logic                bk_ls_rstart,
    input  logic [`ADDR_W-1:0]  bk_ls_raddr,
    output logic [`DATA_W-1:0]  bk_ls_rdata,
    output logic                bk_ls_rdone,

    // SM stream out
    output logic                bk_sm_start,
    output logic [`DATA_W-1:0]  bk_sm_data,
    output logic [`USER_W-1:0]  bk_sm_user,

    // SS stream in
    input  logic [`DATA_W-1:0]  bk_ss_data,
    input  logic [`USER_W-1:0]  bk_ss_user,
    output logic                bk_ss_ready,
    input  logic                bk_ss_valid
);

    import ctrl_pkg::*;

    ls_req_t                ls_in;
    ls_req_t                ls_head;
    logic                   ls_push;
    logic                   ls_full;
    logic                   ls_empty;
    logic                   ls_pop;
    ss_word_t               ss_in;
    ss_word_t               ss_head;
    logic                   ss_push;
    logic                   ss_full;
    logic                   ss_empty;
    logic                   ss_pop;
    req_src_t               dec_src;
    logic                   dec_is_read;
    logic [`SS_ADDR_W-1:0]  dec_addr;
    dest_t                  dec_dest;
    logic                   wr_en;
    logic                   wr_aa;
    logic [2:0]             wr_idx;
    logic [`DATA_W-1:0]     wr_data;
    logic [`STRB_W-1:0]     wr_strb;
    logic                   rd_aa;
    logic [2:0]             rd_idx;
    logic [`DATA_W-1:0]     rd_data;
    logic                   irq_req;

    // write wins over read, reads carry zero data
    assign ls_push      = (bk_ls_wstart || bk_ls_rstart) && !ls_full;
    assign ls_in.is_read = !bk_ls_wstart;
    assign ls_in.addr    = bk_ls_wstart ? bk_ls_waddr : bk_ls_raddr;
    assign ls_in.data    = bk_ls_wstart ? bk_ls_wdata : '0;
    assign ls_in.strb    = bk_ls_wstart ? bk_ls_wstrb : '0;

    assign bk_ss_ready = !ss_full;
    assign ss_push     = bk_ss_valid && bk_ss_ready;
    assign ss_in.data  = bk_ss_data;
    assign ss_in.user  = bk_ss_user;

    req_fifo #(.payload_t(ls_req_t), .DEPTH(`FIFO_DEPTH)) u_ls_fifo (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .push        (ls_push),
        .push_data   (ls_in),
        .full        (ls_full),
        .pop         (ls_pop),
        .head        (ls_head),
        .empty       (ls_empty)
    );

    req_fifo #(.payload_t(ss_word_t), .DEPTH(`FIFO_DEPTH)) u_ss_fifo (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .push        (ss_push),
        .push_data   (ss_in),
        .full        (ss_full),
        .pop         (ss_pop),
        .head        (ss_head),
        .empty       (ss_empty)
    );

    addr_decode u_addr_decode (
        .src     (dec_src),
        .is_read (dec_is_read),
        .addr    (dec_addr),
        .dest    (dec_dest)
    );

    mailbox_regs u_mailbox_regs (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .wr_en         (wr_en),
        .wr_aa         (wr_aa),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .rd_aa         (rd_aa),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .irq_req       (irq_req),
        .axi_interrupt (axi_interrupt)
    );

    bridge_ctrl u_bridge_ctrl (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ls_head     (ls_head),
        .ls_empty    (ls_empty),
        .ls_pop      (ls_pop),
        .ss_head     (ss_head),
        .ss_empty    (ss_empty),
        .ss_pop      (ss_pop),
        .dec_src     (dec_src),
        .dec_is_read (dec_is_read),
        .dec_addr    (dec_addr),
        .dec_dest    (dec_dest),
        .wr_en       (wr_en),
        .wr_aa       (wr_aa),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .rd_aa       (rd_aa),
        .rd_idx      (rd_idx),
        .irq_req     (irq_req),
        .rd_data     (rd_data),
        .bk_ls_rdata (bk_ls_rdata),
        .bk_ls_rdone (bk_ls_rdone),
        .bk_sm_start (bk_sm_start),
        .bk_sm_data  (bk_sm_data),
        .bk_sm_user  (bk_sm_user)
    );

endmodule

//--- bridge_ctrl.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module bridge_ctrl (
    input  logic                   axi_aclk,
    input  logic                   axi_aresetn,
    input  ctrl_pkg::ls_req_t      ls_head,
    input  logic                   ls_empty,
    output logic                   ls_pop,
    input  ctrl_pkg::ss_word_t     ss_head,
    input  logic                   ss_empty,
    output logic                   ss_pop,
    output ctrl_pkg::req_src_t     dec_src,
    output logic                   dec_is_read,
    output logic [`SS_ADDR_W-1:0]  dec_addr,
    input  ctrl_pkg::dest_t        dec_dest,
    output logic                   wr_en,
    output logic                   wr_aa,
    output logic [2:0]             wr_idx,
    output logic [`DATA_W-1:0]     wr_data,
    output logic [`STRB_W-1:0]     wr_strb,
    output logic                   rd_aa,
    output logic [2:0]             rd_idx,
    output logic                   irq_req,
    input  logic [`DATA_W-1:0]     rd_data,
    output logic [`DATA_W-1:0]     bk_ls_rdata,
    output logic                   bk_ls_rdone,
    output logic                   bk_sm_start,
    output logic [`DATA_W-1:0]     bk_sm_data,
    output logic [`USER_W-1:0]     bk_sm_user
);

    import ctrl_pkg::*;

    typedef enum logic [1:0] {IDLE, DECIDE, EXEC, SEND} state_t;

    state_t                 state;
    state_t                 next_state;
    req_src_t               win_src;
    req_src_t               last_src;
    req_src_t               cur_src;
    dest_t                  cur_dest;
    logic [`SS_ADDR_W-1:0]  cur_addr;
    logic [`DATA_W-1:0]     cur_data;
    logic [`STRB_W-1:0]     cur_strb;
    // first word of an SS 01 pair waiting for its data word
    logic                   hold_vld;
    logic [`DATA_W-1:0]     hold_data;
    logic                   ss_is_pair;
    logic                   sm_pair;
    logic                   fwd_rd;
    logic                   ls_rd;

    // round robin, SS wins when LS went last or LS is empty
    assign win_src    = (!ss_empty && (ls_empty || last_src == SRC_LS)) ? SRC_SS : SRC_LS;
    assign ss_is_pair = (ss_head.user == `USER_FWD_WR);

    assign dec_src     = win_src;
    assign dec_is_read = (win_src == SRC_LS) ? ls_head.is_read : 1'b0;
    assign dec_addr    = (win_src == SRC_LS) ?
                         {{(`SS_ADDR_W-`ADDR_W){1'b0}}, ls_head.addr} :
                         hold_data[`SS_ADDR_W-1:0];

    assign ls_pop = (state == DECIDE) && (win_src == SRC_LS);
    assign ss_pop = (state == DECIDE) && (win_src == SRC_SS);

    // LS mailbox writes are mirrored to the link like forwarded writes
    assign sm_pair = (cur_dest == DEST_FWD_WR) ||
                     (cur_dest == DEST_MB_WR && cur_src == SRC_LS);
    assign fwd_rd  = (cur_dest == DEST_FWD_RD);
    assign ls_rd   = (cur_dest == DEST_MB_RD) || (cur_dest == DEST_AA_RD) ||
                     (cur_dest == DEST_UNSUPP_RD);

    // mailbox commands, single cycle in EXEC
    assign wr_en   = (state == EXEC) &&
                     (cur_dest == DEST_MB_WR || cur_dest == DEST_AA_WR);
    assign wr_aa   = (cur_dest == DEST_AA_WR);
    assign wr_idx  = cur_addr[2:0];
    assign wr_data = cur_data;
    assign wr_strb = cur_strb;
    assign rd_aa   = (cur_dest == DEST_AA_RD);
    assign rd_idx  = cur_addr[2:0];
    assign irq_req = (state == EXEC) && (cur_src == SRC_SS) && (cur_dest == DEST_MB_WR);

    //----------------------------------------------------------------------
    // FSM
    //----------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE:
                if (!ls_empty || !ss_empty)
                    next_state = DECIDE;
            DECIDE:
                if (win_src == SRC_LS)
                    next_state = (dec_dest == DEST_DROP) ? IDLE : EXEC;
                else if (hold_vld && ss_is_pair && dec_dest == DEST_MB_WR)
                    next_state = EXEC;
                else
                    next_state = IDLE;
            EXEC:
                next_state = SEND;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state       <= IDLE;
            last_src    <= SRC_SS;
            cur_src     <= SRC_LS;
            cur_dest    <= DEST_DROP;
            hold_vld    <= 1'b0;
            bk_ls_rdone <= 1'b0;
            bk_sm_start <= 1'b0;
        end else begin
            state <= next_state;
            if (state == DECIDE) begin
                last_src <= win_src;
                cur_src  <= win_src;
                cur_dest <= dec_dest;
                if (win_src == SRC_SS && ss_is_pair)
                    hold_vld <= !hold_vld;
            end
            bk_ls_rdone <= (state == EXEC) && ls_rd;
            // pair words go out in EXEC and SEND, back to back
            bk_sm_start <= ((state == EXEC) && (sm_pair || fwd_rd)) ||
                           ((state == SEND) && sm_pair);
        end
    end

    //----------------------------------------------------------------------
    // request and output payload
    //----------------------------------------------------------------------
    always_ff @(posedge axi_aclk) begin
        if (state == DECIDE) begin
            cur_addr <= dec_addr;
            if (win_src == SRC_LS) begin
                cur_data <= ls_head.data;
                cur_strb <= ls_head.strb;
            end else begin
                cur_data <= ss_head.data;
                cur_strb <= hold_data[`DATA_W-1 -: `STRB_W];
                if (ss_is_pair && !hold_vld)
                    hold_data <= ss_head.data;
            end
        end

        if (state == EXEC) begin
            if (ls_rd)
                bk_ls_rdata <= (cur_dest == DEST_UNSUPP_RD) ? `UNSUPP_DATA : rd_data;
            if (sm_pair) begin
                bk_sm_data <= {cur_strb, cur_addr};
                bk_sm_user <= `USER_FWD_WR;
            end else if (fwd_rd) begin
                bk_sm_data <= {{(`DATA_W-`SS_ADDR_W){1'b0}}, cur_addr};
                bk_sm_user <= `USER_FWD_RD;
            end
        end else if (state == SEND && sm_pair) begin
            bk_sm_data <= cur_data;
            bk_sm_user <= `USER_FWD_WR;
        end
    end

endmodule

//--- ctrl_defs.svh
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// datapath widths
`define DATA_W      32
`define ADDR_W      15
`define SS_ADDR_W   28
`define STRB_W      4
`define USER_W      2

`define FIFO_DEPTH  8

// local register block
`define MB_LOW      'h2000
`define MB_HIGH     'h2007
`define AA_LOW      'h2100
`define AA_HIGH     'h2101
`define LOCAL_HIGH  'h2FFF

// user windows forwarded to the stream link
`define USER0_LOW   'h0000
`define USER0_HIGH  'h1FFF
`define USER1_LOW   'h3000
`define USER1_HIGH  'h4FFF

`define UNSUPP_DATA {`DATA_W{1'b1}}
`define USER_FWD_WR 2'b01
`define USER_FWD_RD 2'b10

`endif

//--- ctrl_pkg.sv
`include "ctrl_defs.svh"

package ctrl_pkg;

    // one queued LS request, 52 bits
    typedef struct packed {
        logic                 is_read;
        logic [`ADDR_W-1:0]   addr;
        logic [`DATA_W-1:0]   data;
        logic [`STRB_W-1:0]   strb;
    } ls_req_t;

    // one queued SS stream word, 34 bits
    typedef struct packed {
        logic [`DATA_W-1:0]   data;
        logic [`USER_W-1:0]   user;
    } ss_word_t;

    // decoded action for the current request
    typedef enum logic [2:0] {
        DEST_MB_WR,
        DEST_MB_RD,
        DEST_AA_WR,
        DEST_AA_RD,
        DEST_UNSUPP_RD,
        DEST_FWD_WR,
        DEST_FWD_RD,
        DEST_DROP
    } dest_t;

    typedef enum logic {
        SRC_LS,
        SRC_SS
    } req_src_t;

endpackage

//--- mailbox_regs.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module mailbox_regs (
    input  logic                axi_aclk,
    input  logic                axi_aresetn,
    input  logic                wr_en,
    input  logic                wr_aa,
    input  logic [2:0]          wr_idx,
    input  logic [`DATA_W-1:0]  wr_data,
    input  logic [`STRB_W-1:0]  wr_strb,
    input  logic                rd_aa,
    input  logic [2:0]          rd_idx,
    output logic [`DATA_W-1:0]  rd_data,
    input  logic                irq_req,
    output logic                axi_interrupt
);

    logic [`DATA_W-1:0] mb [8];
    // AA offset 0 bit 0
    logic               int_en;
    // AA offset 1 bit 0, write 1 to clear
    logic               int_status;

    //----------------------------------------------------------------------
    // register writes and interrupt
    //----------------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int i = 0; i < 8; i++) begin
                mb[i] <= '0;
            end
            int_en        <= 1'b0;
            int_status    <= 1'b0;
            axi_interrupt <= 1'b0;
        end else begin
            axi_interrupt <= irq_req && int_en;

            // byte masked mailbox write
            if (wr_en && !wr_aa) begin
                for (int b = 0; b < `STRB_W; b++) begin
                    if (wr_strb[b]) begin
                        mb[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end

            if (wr_en && wr_aa && wr_strb[0]) begin
                if (!wr_idx[0])
                    int_en <= wr_data[0];
                else if (wr_data[0])
                    int_status <= 1'b0;
            end

            // remote write raises status only when enabled
            if (irq_req && int_en) begin
                int_status <= 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // read mux
    //----------------------------------------------------------------------
    always_comb begin
        if (rd_aa)
            rd_data = {{(`DATA_W-1){1'b0}}, (rd_idx[0] ? int_status : int_en)};
        else
            rd_data = mb[rd_idx];
    end

endmodule

//--- req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     axi_aclk,
    input  logic     axi_aresetn,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t head,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign head    = mem[rd_ptr];

    // storage
    always_ff @(posedge axi_aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at DEPTH, count tracks occupancy
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_axi_ctrl_logic \
    -Mdir obj_dir -o tb_sim -f verilog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

//--- tb_axi_ctrl_logic.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module tb_axi_ctrl_logic;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    // rough count of LS and SS operations over all tests
    localparam int NUM_OPS      = 70;
    localparam int OP_CYCLES    = 16;
    localparam int BUDGET       = (RESET_CYCLES + NUM_OPS * OP_CYCLES) * 4;
    localparam int WAIT_LIMIT   = 60;
    localparam int SETTLE       = 12;

    localparam logic [`ADDR_W-1:0] MB_BASE    = 15'(`MB_LOW);
    localparam logic [`ADDR_W-1:0] MB_TOP     = 15'(`MB_HIGH);
    localparam logic [`ADDR_W-1:0] AA_EN_ADDR = 15'(`AA_LOW);
    localparam logic [`ADDR_W-1:0] AA_ST_ADDR = 15'(`AA_HIGH);

    logic                axi_aclk;
    logic                axi_aresetn;
    logic                axi_interrupt;
    logic                bk_ls_wstart;
    logic [`ADDR_W-1:0]  bk_ls_waddr;
    logic [`DATA_W-1:0]  bk_ls_wdata;
    logic [`STRB_W-1:0]  bk_ls_wstrb;
    logic                bk_ls_rstart;
    logic [`ADDR_W-1:0]  bk_ls_raddr;
    logic [`DATA_W-1:0]  bk_ls_rdata;
    logic                bk_ls_rdone;
    logic                bk_sm_start;
    logic [`DATA_W-1:0]  bk_sm_data;
    logic [`USER_W-1:0]  bk_sm_user;
    logic [`DATA_W-1:0]  bk_ss_data;
    logic [`USER_W-1:0]  bk_ss_user;
    logic                bk_ss_ready;
    logic                bk_ss_valid;

    // register model
    logic [`DATA_W-1:0]  ref_mb [8];
    logic                ref_en;
    logic                ref_st;
    logic [15:0]         lfsr;

    // expected responses with SM words packed as {user, data}
    logic [`USER_W+`DATA_W-1:0] exp_sm [$];
    logic [`DATA_W-1:0]         exp_rd [$];
    int                         exp_irq;
    // header of an SM write seen, data word due next cycle
    logic                       sm_half;
    int                         errors;
    int                         checks;
    int                         tests_run;
    int                         tests_failed;
    int                         test_errors;

    axi_ctrl_logic u_dut (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .axi_interrupt (axi_interrupt),
        .bk_ls_wstart  (bk_ls_wstart),
        .bk_ls_waddr   (bk_ls_waddr),
        .bk_ls_wdata   (bk_ls_wdata),
        .bk_ls_wstrb   (bk_ls_wstrb),
        .bk_ls_rstart  (bk_ls_rstart),
        .bk_ls_raddr   (bk_ls_raddr),
        .bk_ls_rdata   (bk_ls_rdata),
        .bk_ls_rdone   (bk_ls_rdone),
        .bk_sm_start   (bk_sm_start),
        .bk_sm_data    (bk_sm_data),
        .bk_sm_user    (bk_sm_user),
        .bk_ss_data    (bk_ss_data),
        .bk_ss_user    (bk_ss_user),
        .bk_ss_ready   (bk_ss_ready),
        .bk_ss_valid   (bk_ss_valid)
    );

    initial begin
        axi_aclk = 1'b0;
        forever #(CLK_PERIOD / 2) axi_aclk = ~axi_aclk;
    end

    // ----------------------------------------------------------------------
    // helpers and reference model
    // ----------------------------------------------------------------------

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = data[8*b +: 8];
            end
        end
        return r;
    endfunction

    // window 0 starts at address zero
    function automatic logic is_user_addr(input logic [`ADDR_W-1:0] addr);
        return (addr <= 15'(`USER0_HIGH)) ||
               ((addr >= 15'(`USER1_LOW)) && (addr <= 15'(`USER1_HIGH)));
    endfunction

    // expected LS read data with all ones for unserved reads
    function automatic logic [31:0] ref_read(input logic [`ADDR_W-1:0] addr);
        if ((addr >= MB_BASE) && (addr <= MB_TOP))
            return ref_mb[addr[2:0]];
        if (addr == AA_EN_ADDR)
            return {31'b0, ref_en};
        if (addr == AA_ST_ADDR)
            return {31'b0, ref_st};
        return `UNSUPP_DATA;
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic ls_write(input logic [`ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        logic [31:0] header;
        header = {strb, 13'b0, addr};
        if ((addr >= MB_BASE) && (addr <= MB_TOP)) begin
            ref_mb[addr[2:0]] = merge_bytes(ref_mb[addr[2:0]], data, strb);
            exp_sm.push_back({`USER_FWD_WR, header});
            exp_sm.push_back({`USER_FWD_WR, data});
        end else if (addr == AA_EN_ADDR) begin
            if (strb[0])
                ref_en = data[0];
        end else if (addr == AA_ST_ADDR) begin
            if (strb[0] && data[0])
                ref_st = 1'b0;
        end else if (is_user_addr(addr)) begin
            exp_sm.push_back({`USER_FWD_WR, header});
            exp_sm.push_back({`USER_FWD_WR, data});
        end
        @(posedge axi_aclk);
        bk_ls_wstart <= 1'b1;
        bk_ls_waddr  <= addr;
        bk_ls_wdata  <= data;
        bk_ls_wstrb  <= strb;
        @(posedge axi_aclk);
        bk_ls_wstart <= 1'b0;
    endtask

    task automatic ls_read(input logic [`ADDR_W-1:0] addr);
        if (is_user_addr(addr))
            exp_sm.push_back({`USER_FWD_RD, 17'b0, addr});
        else
            exp_rd.push_back(ref_read(addr));
        @(posedge axi_aclk);
        bk_ls_rstart <= 1'b1;
        bk_ls_raddr  <= addr;
        @(posedge axi_aclk);
        bk_ls_rstart <= 1'b0;
    endtask

    // one stream word held until the FIFO accepts it
    task automatic ss_send(input logic [31:0] data, input logic [1:0] user);
        @(posedge axi_aclk);
        bk_ss_valid <= 1'b1;
        bk_ss_data  <= data;
        bk_ss_user  <= user;
        @(negedge axi_aclk);
        while (!bk_ss_ready) @(negedge axi_aclk);
        @(posedge axi_aclk);
        bk_ss_valid <= 1'b0;
    endtask

    task automatic ss_mb_write(input logic [2:0] idx, input logic [31:0] data,
                               input logic [3:0] strb);
        ref_mb[idx] = merge_bytes(ref_mb[idx], data, strb);
        if (ref_en) begin
            ref_st = 1'b1;
            exp_irq++;
        end
        ss_send({strb, 28'(`MB_LOW) + 28'(idx)}, `USER_FWD_WR);
        ss_send(data, `USER_FWD_WR);
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while ((exp_sm.size() != 0 || exp_rd.size() != 0 || exp_irq != 0) &&
               n < WAIT_LIMIT) begin
            @(negedge axi_aclk);
            n++;
        end
        if (exp_sm.size() != 0 || exp_rd.size() != 0 || exp_irq != 0) begin
            $display("no response from the DUT while waiting for %s", what);
            errors++;
            exp_sm.delete();
            exp_rd.delete();
            exp_irq = 0;
        end
        // quiet window so stray pulses show up in this test
        repeat (SETTLE) @(negedge axi_aclk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_errors = errors;
    endtask

    // ----------------------------------------------------------------------
    // output checker
    // ----------------------------------------------------------------------
    always @(negedge axi_aclk) begin : output_checker
        logic [`USER_W+`DATA_W-1:0] exp_word;
        if (axi_aresetn) begin
            if (sm_half && !bk_sm_start) begin
                errors++;
                $display("data word of an SM write did not follow its header");
                sm_half = 1'b0;
            end
            if (bk_sm_start) begin
                if (exp_sm.size() == 0) begin
                    errors++;
                    $display("unexpected SM word 0x%h with user code %0h",
                             bk_sm_data, bk_sm_user);
                end else begin
                    exp_word = exp_sm.pop_front();
                    check("bk_sm_user", 64'(bk_sm_user), 64'(exp_word[33:32]));
                    check("bk_sm_data", 64'(bk_sm_data), 64'(exp_word[31:0]));
                    sm_half = (exp_word[33:32] == `USER_FWD_WR) && !sm_half;
                end
            end
            if (bk_ls_rdone) begin
                if (exp_rd.size() == 0) begin
                    errors++;
                    $display("unexpected LS read response 0x%h", bk_ls_rdata);
                end else begin
                    check("bk_ls_rdata", 64'(bk_ls_rdata), 64'(exp_rd.pop_front()));
                end
            end
            if (axi_interrupt) begin
                if (exp_irq == 0) begin
                    errors++;
                    $display("unexpected interrupt pulse");
                end else begin
                    exp_irq--;
                end
            end
        end
    end

    initial begin
        repeat (BUDGET) @(posedge axi_aclk);
        $display("watchdog expired after %0d cycles, the tests did not finish", BUDGET);
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    initial begin
        logic [31:0] rnd_data;
        logic [31:0] rnd_strb;
        axi_aresetn  = 1'b0;
        bk_ls_wstart = 1'b0;
        bk_ls_waddr  = '0;
        bk_ls_wdata  = '0;
        bk_ls_wstrb  = '0;
        bk_ls_rstart = 1'b0;
        bk_ls_raddr  = '0;
        bk_ss_data   = '0;
        bk_ss_user   = '0;
        bk_ss_valid  = 1'b0;
        lfsr         = 16'd1478;
        ref_en       = 1'b0;
        ref_st       = 1'b0;
        exp_irq      = 0;
        sm_half      = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        for (int i = 0; i < 8; i++) begin
            ref_mb[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge axi_aclk);
        axi_aresetn <= 1'b1;
        @(negedge axi_aclk);

        check("axi_interrupt", 64'(axi_interrupt), 64'd0);
        check("bk_ls_rdone", 64'(bk_ls_rdone), 64'd0);
        check("bk_sm_start", 64'(bk_sm_start), 64'd0);
        check("bk_ss_ready", 64'(bk_ss_ready), 64'd1);
        for (int i = 0; i < 8; i++) begin
            ls_read(MB_BASE + 15'(i));
        end
        wait_done("mailbox reads after reset");
        finish_test("reset state");

        // two rounds so the second merges into the first
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 8; i++) begin
                rand_bits(32, rnd_data);
                rand_bits(4, rnd_strb);
                ls_write(MB_BASE + 15'(i), rnd_data, rnd_strb[3:0]);
            end
            wait_done("mailbox writes");
        end
        for (int i = 0; i < 8; i++) begin
            ls_read(MB_BASE + 15'(i));
        end
        wait_done("mailbox read back");
        finish_test("mailbox byte writes");

        ls_read(AA_EN_ADDR);
        ls_read(AA_ST_ADDR);
        ls_write(AA_EN_ADDR, 32'h1, 4'h1);
        ls_read(AA_EN_ADDR);
        ls_write(AA_ST_ADDR, 32'h1, 4'h1);
        ls_read(AA_ST_ADDR);
        ls_write(AA_EN_ADDR, 32'h0, 4'h1);
        wait_done("AA register access");
        ls_read(15'h2008);
        ls_read(15'h2102);
        ls_read(15'h5000);
        // bit 0 set so a stray enable write would show up
        rand_bits(32, rnd_data);
        ls_write(15'h2200, rnd_data | 32'h1, 4'hf);
        wait_done("unsupported accesses");
        for (int i = 0; i < 8; i++) begin
            ls_read(MB_BASE + 15'(i));
        end
        wait_done("mailbox after ignored write");
        ls_read(AA_EN_ADDR);
        ls_read(AA_ST_ADDR);
        wait_done("AA after ignored write");
        finish_test("AA and unsupported");

        rand_bits(32, rnd_data);
        rand_bits(4, rnd_strb);
        ls_write(15'h0100, rnd_data, rnd_strb[3:0]);
        rand_bits(32, rnd_data);
        ls_write(15'h3abc, rnd_data, 4'hf);
        ls_read(15'h1234);
        ls_read(15'h4ffe);
        wait_done("forwarded accesses");
        finish_test("user window forwarding");

        ls_write(AA_EN_ADDR, 32'h1, 4'h1);
        wait_done("interrupt enable");
        rand_bits(32, rnd_data);
        rand_bits(4, rnd_strb);
        ss_mb_write(3'd3, rnd_data, rnd_strb[3:0] | 4'h1);
        wait_done("remote write with interrupt");
        ls_read(MB_BASE + 15'd3);
        ls_read(AA_ST_ADDR);
        ls_write(AA_ST_ADDR, 32'h1, 4'h1);
        ls_read(AA_ST_ADDR);
        ls_write(AA_EN_ADDR, 32'h0, 4'h1);
        wait_done("status clear");
        rand_bits(32, rnd_data);
        ss_mb_write(3'd5, rnd_data, 4'hf);
        wait_done("remote write without interrupt");
        ls_read(MB_BASE + 15'd5);
        ls_read(AA_ST_ADDR);
        wait_done("reads after remote write");
        finish_test("remote mailbox writes");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
ctrl_pkg.sv
req_fifo.sv
addr_decode.sv
mailbox_regs.sv
bridge_ctrl.sv
axi_ctrl_logic.sv
tb_axi_ctrl_logic.sv
